//--- src/tilemap_cfg.svh
`ifndef TILEMAP_CFG_SVH
`define TILEMAP_CFG_SVH

// Beam counters and scroll registers
`define POS_W 9

// Tile RAM word address, 64 x 64 map
`define TILE_ADDR_W 12

// CPU byte address, bit 0 picks the byte lane
`define CPU_ADDR_W 13

// Pattern ROM address: tile code then fine y
`define PAT_ADDR_W 14

// Fields of one tile RAM word
`define TILE_CODE_W 11
`define ATTR_W 5

`endif

//--- src/tilemapPkg.sv
`include "tilemap_cfg.svh"

package tilemapPkg;

	//////////////////////////////////////////////////
	// Tile RAM word views
	//////////////////////////////////////////////////

	// CPU side sees two bytes
	typedef struct packed {
		logic [7:0] hi;
		logic [7:0] lo;
	} byteView_s;

	// Layer side sees attribute over code
	typedef struct packed {
		logic [`ATTR_W-1:0] attr;
		logic [`TILE_CODE_W-1:0] code;
	} tileView_s;

	typedef union packed {
		byteView_s bytes;
		tileView_s tile;
	} tileWord_u;

	//////////////////////////////////////////////////
	// Ports between blocks
	//////////////////////////////////////////////////

	typedef struct packed {
		logic [`POS_W-1:0] hPos;
		logic [`POS_W-1:0] vPos;
	} beamPos_s;

	// regSel picks scroll registers over tile RAM
	typedef struct packed {
		logic regSel;
		logic write;
		logic [`CPU_ADDR_W-1:0] addr;
		logic [7:0] wdata;
	} cpuReq_s;

	typedef struct packed {
		logic [1:0] idx;
		logic [7:0] data;
	} regWrite_s;

	// Row in the upper half, column in the lower half
	typedef struct packed {
		logic [`TILE_ADDR_W-1:0] addr;
	} fetchReq_s;

	typedef struct packed {
		logic [`PAT_ADDR_W-1:0] patAddr;
		logic [`ATTR_W-1:0] attr;
		logic [2:0] fineX;
	} patFetch_s;

endpackage

//--- src/videoTiming.sv
`timescale 1ns/100ps
`include "tilemap_cfg.svh"

module videoTiming (
	input logic clk6M,
	input logic rstN,
	input logic hSyncN,
	input logic vSyncN,
	output tilemapPkg::beamPos_s beamPos
);

	// Registered sync copies for edge detection
	logic hSyncD;
	logic vSyncD;
	logic hFall;
	logic vFall;
	// Vsync fell somewhere in the current line
	logic vPending;

	assign hFall = hSyncD & ~hSyncN;
	assign vFall = vSyncD & ~vSyncN;

	always_ff @(posedge clk6M or negedge rstN) begin
		if (!rstN) begin
			hSyncD <= 1'b1;
			vSyncD <= 1'b1;
		end else begin
			hSyncD <= hSyncN;
			vSyncD <= vSyncN;
		end
	end

	// Horizontal counter restarts on each hsync fall
	// Vertical counter steps once per line
	always_ff @(posedge clk6M or negedge rstN) begin
		if (!rstN) begin
			beamPos <= '0;
			vPending <= 1'b0;
		end else begin
			if (hFall) begin
				beamPos.hPos <= '0;
				// New frame if vsync dropped since last line
				if (vPending || vFall)
					beamPos.vPos <= '0;
				else
					beamPos.vPos <= beamPos.vPos + 1'b1;
				vPending <= 1'b0;
			end else begin
				beamPos.hPos <= beamPos.hPos + 1'b1;
				if (vFall)
					vPending <= 1'b1;
			end
		end
	end

endmodule

//--- src/tileLayer.sv
`timescale 1ns/100ps
`include "tilemap_cfg.svh"

module tileLayer (
	input logic clk6M,
	input logic rstN,
	input logic vSyncN,
	input tilemapPkg::beamPos_s beamPos,
	input logic regWe,
	input tilemapPkg::regWrite_s regWrite,
	output logic fetchValid,
	output tilemapPkg::fetchReq_s fetchReq,
	input logic fetchReady,
	input tilemapPkg::tileWord_u fetchData,
	output logic patFetchValid,
	output tilemapPkg::patFetch_s patFetch
);

	// Live copies, written by the CPU
	logic [`POS_W-1:0] scrollXLive;
	logic [`POS_W-1:0] scrollYLive;
	logic flipLive;
	// Frame copies, used for fetching
	logic [`POS_W-1:0] scrollXShadow;
	logic [`POS_W-1:0] scrollYShadow;
	logic flipShadow;
	logic vSyncD;
	logic vFall;
	// Scrolled map position
	logic [`POS_W-1:0] xPos;
	logic [`POS_W-1:0] yPos;
	logic fetchStart;
	logic fetchGrant;
	// Request stage payload
	logic [2:0] reqFineY;
	logic [2:0] reqFineX;
	// Grant stage, RAM data due next cycle
	logic gntValid;
	logic [2:0] gntFineY;
	logic [2:0] gntFineX;

	//////////////////////////////////////////////////
	// Scroll registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk6M or negedge rstN) begin
		if (!rstN) begin
			scrollXLive <= '0;
			scrollYLive <= '0;
			flipLive <= 1'b0;
		end else if (regWe) begin
			case (regWrite.idx)
				2'd0: scrollXLive[`POS_W-2:0] <= regWrite.data;
				2'd1: begin
					scrollXLive[`POS_W-1] <= regWrite.data[0];
					flipLive <= regWrite.data[7];
				end
				2'd2: scrollYLive[`POS_W-2:0] <= regWrite.data;
				default: scrollYLive[`POS_W-1] <= regWrite.data[0];
			endcase
		end
	end

	assign vFall = vSyncD & ~vSyncN;

	// Shadows take effect from the next frame
	always_ff @(posedge clk6M or negedge rstN) begin
		if (!rstN) begin
			vSyncD <= 1'b1;
			scrollXShadow <= '0;
			scrollYShadow <= '0;
			flipShadow <= 1'b0;
		end else begin
			vSyncD <= vSyncN;
			if (vFall) begin
				scrollXShadow <= scrollXLive;
				scrollYShadow <= scrollYLive;
				flipShadow <= flipLive;
			end
		end
	end

	//////////////////////////////////////////////////
	// Tile fetch
	//////////////////////////////////////////////////

	// Flip mirrors the beam, wraps mod 512
	always_comb begin
		xPos = (flipShadow ? ~beamPos.hPos : beamPos.hPos) + scrollXShadow;
		yPos = (flipShadow ? ~beamPos.vPos : beamPos.vPos) + scrollYShadow;
	end

	// One request per 8-pixel column
	assign fetchStart = ~fetchValid & (xPos[2:0] == 3'd0);
	assign fetchGrant = fetchValid & fetchReady;

	always_ff @(posedge clk6M or negedge rstN) begin
		if (!rstN) begin
			fetchValid <= 1'b0;
			gntValid <= 1'b0;
			patFetchValid <= 1'b0;
		end else begin
			if (fetchStart)
				fetchValid <= 1'b1;
			else if (fetchGrant)
				fetchValid <= 1'b0;
			gntValid <= fetchGrant;
			patFetchValid <= gntValid;
		end
	end

	// Payload held steady until granted
	always_ff @(posedge clk6M) begin
		if (fetchStart) begin
			fetchReq.addr <= {yPos[`POS_W-1:3], xPos[`POS_W-1:3]};
			reqFineY <= yPos[2:0];
			reqFineX <= scrollXShadow[2:0];
		end
		if (fetchGrant) begin
			gntFineY <= reqFineY;
			gntFineX <= reqFineX;
		end
		// Word arrives here, decode as code and attribute
		if (gntValid) begin
			patFetch.patAddr <= {fetchData.tile.code, gntFineY};
			patFetch.attr <= fetchData.tile.attr;
			patFetch.fineX <= gntFineX;
		end
	end

endmodule

//--- src/tileRam.sv
`timescale 1ns/100ps
`include "tilemap_cfg.svh"

module tileRam (
	input logic clk6M,
	input logic rstN,
	input logic fetchValidA,
	input logic fetchValidB,
	input tilemapPkg::fetchReq_s fetchReqA,
	input tilemapPkg::fetchReq_s fetchReqB,
	output logic fetchReadyA,
	output logic fetchReadyB,
	output tilemapPkg::tileWord_u fetchDataA,
	output tilemapPkg::tileWord_u fetchDataB,
	input logic cpuRamValid,
	input tilemapPkg::cpuReq_s cpuReq,
	output logic cpuRamReady,
	output logic [7:0] cpuRdata,
	output logic cpuRspValid
);

	localparam int ramDepth = 1 << `TILE_ADDR_W;

	tilemapPkg::tileWord_u mem [ramDepth];
	tilemapPkg::tileWord_u rdWord;
	logic [`TILE_ADDR_W-1:0] ramAddr;
	logic [`TILE_ADDR_W-1:0] cpuWordAddr;
	// CPU port opens one cycle after reset
	logic ramPortEn;
	logic cpuAccept;
	logic rdByteHi;

	//////////////////////////////////////////////////
	// Fixed priority arbitration
	//////////////////////////////////////////////////

	// Layer A always wins
	assign fetchReadyA = 1'b1;
	assign fetchReadyB = ~fetchValidA;
	// CPU only gets idle slots
	assign cpuRamReady = ramPortEn & ~fetchValidA & ~fetchValidB;
	assign cpuAccept = cpuRamValid & cpuRamReady;

	assign cpuWordAddr = cpuReq.addr[`CPU_ADDR_W-1:1];

	always_comb begin
		if (fetchValidA)
			ramAddr = fetchReqA.addr;
		else if (fetchValidB)
			ramAddr = fetchReqB.addr;
		else
			ramAddr = cpuWordAddr;
	end

	//////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////

	// Byte lane writes, single read port
	always_ff @(posedge clk6M) begin
		if (cpuAccept && cpuReq.write) begin
			if (cpuReq.addr[0])
				mem[cpuWordAddr].bytes.hi <= cpuReq.wdata;
			else
				mem[cpuWordAddr].bytes.lo <= cpuReq.wdata;
		end
		rdWord <= mem[ramAddr];
		rdByteHi <= cpuReq.addr[0];
	end

	always_ff @(posedge clk6M or negedge rstN) begin
		if (!rstN) begin
			ramPortEn <= 1'b0;
			cpuRspValid <= 1'b0;
		end else begin
			ramPortEn <= 1'b1;
			cpuRspValid <= cpuAccept & ~cpuReq.write;
		end
	end

	// Same word goes to whichever port was granted
	assign fetchDataA = rdWord;
	assign fetchDataB = rdWord;
	assign cpuRdata = rdByteHi ? rdWord.bytes.hi : rdWord.bytes.lo;

endmodule

//--- src/tilemapGen.sv
`timescale 1ns/100ps

module tilemapGen (
	input logic clk6M,
	input logic rstN,
	input logic hSyncN,
	input logic vSyncN,
	input logic cpuReqValid,
	input tilemapPkg::cpuReq_s cpuReq,
	output logic cpuReqReady,
	output logic [7:0] cpuRdata,
	output logic cpuRspValid,
	output logic patFetchValidA,
	output logic patFetchValidB,
	output tilemapPkg::patFetch_s patFetchA,
	output tilemapPkg::patFetch_s patFetchB
);

	tilemapPkg::beamPos_s beamPos;
	tilemapPkg::regWrite_s regWrite;
	tilemapPkg::fetchReq_s fetchReqA;
	tilemapPkg::fetchReq_s fetchReqB;
	tilemapPkg::tileWord_u fetchDataA;
	tilemapPkg::tileWord_u fetchDataB;
	logic fetchValidA;
	logic fetchValidB;
	logic fetchReadyA;
	logic fetchReadyB;
	logic cpuRamValid;
	logic cpuRamReady;
	// Register port opens one cycle after reset
	logic regPortEn;
	logic regAccept;
	logic regWeA;
	logic regWeB;

	always_ff @(posedge clk6M or negedge rstN) begin
		if (!rstN)
			regPortEn <= 1'b0;
		else
			regPortEn <= 1'b1;
	end

	//////////////////////////////////////////////////
	// CPU request split
	//////////////////////////////////////////////////

	assign cpuRamValid = cpuReqValid & ~cpuReq.regSel;
	assign cpuReqReady = cpuReq.regSel ? regPortEn : cpuRamReady;

	// Write-only registers, address bit 2 picks layer B
	assign regAccept = cpuReqValid & cpuReq.regSel & regPortEn & cpuReq.write;
	assign regWeA = regAccept & ~cpuReq.addr[2];
	assign regWeB = regAccept & cpuReq.addr[2];
	assign regWrite.idx = cpuReq.addr[1:0];
	assign regWrite.data = cpuReq.wdata;

	videoTiming videoTiming_i (
		.clk6M(clk6M),
		.rstN(rstN),
		.hSyncN(hSyncN),
		.vSyncN(vSyncN),
		.beamPos(beamPos)
	);

	tileLayer layerA (
		.clk6M(clk6M),
		.rstN(rstN),
		.vSyncN(vSyncN),
		.beamPos(beamPos),
		.regWe(regWeA),
		.regWrite(regWrite),
		.fetchValid(fetchValidA),
		.fetchReq(fetchReqA),
		.fetchReady(fetchReadyA),
		.fetchData(fetchDataA),
		.patFetchValid(patFetchValidA),
		.patFetch(patFetchA)
	);

	tileLayer layerB (
		.clk6M(clk6M),
		.rstN(rstN),
		.vSyncN(vSyncN),
		.beamPos(beamPos),
		.regWe(regWeB),
		.regWrite(regWrite),
		.fetchValid(fetchValidB),
		.fetchReq(fetchReqB),
		.fetchReady(fetchReadyB),
		.fetchData(fetchDataB),
		.patFetchValid(patFetchValidB),
		.patFetch(patFetchB)
	);

	// Shared RAM, layers ahead of the CPU
	tileRam tileRam_i (
		.clk6M(clk6M),
		.rstN(rstN),
		.fetchValidA(fetchValidA),
		.fetchValidB(fetchValidB),
		.fetchReqA(fetchReqA),
		.fetchReqB(fetchReqB),
		.fetchReadyA(fetchReadyA),
		.fetchReadyB(fetchReadyB),
		.fetchDataA(fetchDataA),
		.fetchDataB(fetchDataB),
		.cpuRamValid(cpuRamValid),
		.cpuReq(cpuReq),
		.cpuRamReady(cpuRamReady),
		.cpuRdata(cpuRdata),
		.cpuRspValid(cpuRspValid)
	);

endmodule

//--- verification/tilemapGen_assertions.sv
`timescale 1ns/100ps

module tilemapGen_assertions (
	input logic clk6M,
	input logic rstN,
	input logic fetchValidA,
	input logic fetchValidB,
	input tilemapPkg::fetchReq_s fetchReqB,
	input logic fetchReadyB,
	input logic cpuRamValid,
	input logic cpuRamReady,
	input logic cpuReqReady,
	input tilemapPkg::cpuReq_s cpuReq,
	input logic cpuRspValid,
	input logic patFetchValidA,
	input logic patFetchValidB
);

	// Only layer B can wait, its address stays put meanwhile
	holdB: assert property (@(posedge clk6M) disable iff (!rstN)
		fetchValidB && !fetchReadyB |=> fetchValidB && $stable(fetchReqB))
		else $error("layer B fetch request changed before its grant");

	rspAfterRead: assert property (@(posedge clk6M) disable iff (!rstN)
		cpuRspValid |-> $past(cpuRamValid && cpuRamReady && !cpuReq.write))
		else $error("read response without an accepted read");

	inReset: assert property (@(posedge clk6M)
		!rstN |-> !cpuReqReady && !cpuRspValid && !patFetchValidA && !patFetchValidB
			&& !fetchValidA && !fetchValidB)
		else $error("control output high during reset");

endmodule

bind tilemapGen tilemapGen_assertions tilemapGenChecks_i (
	.clk6M(clk6M),
	.rstN(rstN),
	.fetchValidA(fetchValidA),
	.fetchValidB(fetchValidB),
	.fetchReqB(fetchReqB),
	.fetchReadyB(fetchReadyB),
	.cpuRamValid(cpuRamValid),
	.cpuRamReady(cpuRamReady),
	.cpuReqReady(cpuReqReady),
	.cpuReq(cpuReq),
	.cpuRspValid(cpuRspValid),
	.patFetchValidA(patFetchValidA),
	.patFetchValidB(patFetchValidB)
);

//--- verification/tilemapGenTb.sv
`timescale 1ns/100ps
`include "tilemap_cfg.svh"

module tilemapGenTb;

	localparam int clkPeriod = 20;
	localparam int ramBytes = 1 << `CPU_ADDR_W;
	// Fill gets at most half the slots stolen by fetches
	localparam int fillCycleMax = 2 * ramBytes;
	localparam int randomCycles = 6000;
	localparam int drainCycles = 16;
	localparam int totalCycles = 5 + fillCycleMax + randomCycles + 3 * drainCycles;

	typedef struct packed {
		tilemapPkg::patFetch_s val;
		tilemapPkg::patFetch_s mask;
	} expEntry_s;

	logic clk6M;
	logic rstN;
	logic hSyncN;
	logic vSyncN;
	logic cpuReqValid;
	tilemapPkg::cpuReq_s cpuReq;
	logic cpuReqReady;
	logic [7:0] cpuRdata;
	logic cpuRspValid;
	logic patFetchValidA;
	logic patFetchValidB;
	tilemapPkg::patFetch_s patFetchA;
	tilemapPkg::patFetch_s patFetchB;

	// Reference model state
	logic [7:0] mirror [ramBytes];
	logic byteKnown [ramBytes];
	logic [`POS_W-1:0] hPos;
	logic [`POS_W-1:0] vPos;
	logic hSyncD;
	logic vSyncD;
	logic vPending;
	logic [`POS_W-1:0] scrollXLive [2];
	logic [`POS_W-1:0] scrollYLive [2];
	logic flipLive [2];
	logic [`POS_W-1:0] scrollXShadow [2];
	logic [`POS_W-1:0] scrollYShadow [2];
	logic flipShadow [2];
	logic fetchPend [2];
	logic [`TILE_ADDR_W-1:0] reqAddr [2];
	logic [2:0] reqFineY [2];
	logic [2:0] reqFineX [2];
	logic gntStage [2];
	logic outExp [2];
	logic portEn;
	logic rspExp;
	logic [7:0] rspByte;
	logic readyAtNeg;
	logic cpuAccepted;
	expEntry_s expQA [$];
	expEntry_s expQB [$];
	// Sync generator and fill pointer
	int lineCnt;
	int lineLen;
	int lineIdx;
	int frameLines;
	int fillAddr;

	tilemapGen tilemapGen_i (
		.clk6M(clk6M),
		.rstN(rstN),
		.hSyncN(hSyncN),
		.vSyncN(vSyncN),
		.cpuReqValid(cpuReqValid),
		.cpuReq(cpuReq),
		.cpuReqReady(cpuReqReady),
		.cpuRdata(cpuRdata),
		.cpuRspValid(cpuRspValid),
		.patFetchValidA(patFetchValidA),
		.patFetchValidB(patFetchValidB),
		.patFetchA(patFetchA),
		.patFetchB(patFetchB)
	);

	initial begin
		clk6M = 1'b0;
		forever #(clkPeriod / 2) clk6M = ~clk6M;
	end

	// Ready is combinational, look at it mid cycle
	always @(negedge clk6M)
		readyAtNeg = cpuReqReady;

	initial begin
		#(totalCycles * clkPeriod + 2000);
		reportFailure("timeout, the run did not reach its end in time");
	end

	//////////////////////////////////////////////////
	// Failure reporting and compares
	//////////////////////////////////////////////////

	task automatic stopOnFailure();
		$display("SIMULATION FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic reportFailure(string msg);
		$display("Error: %s", msg);
		stopOnFailure();
	endtask

	task automatic checkPatFetch(string name, tilemapPkg::patFetch_s got,
		tilemapPkg::patFetch_s exp, tilemapPkg::patFetch_s mask);
		if (((got ^ exp) & mask) !== '0) begin
			$display("[FAIL] %s got %h expected %h mask %h", name, got, exp, mask);
			stopOnFailure();
		end
	endtask

	task automatic checkCpuRdata(logic [7:0] got, logic [7:0] exp);
		if (got !== exp) begin
			$display("[FAIL] cpuRdata got %h expected %h", got, exp);
			stopOnFailure();
		end
	endtask

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	// Mixes every address bit into the byte
	function automatic logic [7:0] fillByte(int a);
		logic [12:0] x;
		x = a[12:0];
		return x[7:0] ^ {x[12:8], x[12:10]};
	endfunction

	// Word is hi:lo, attribute on top, code below
	function automatic expEntry_s makeExpected(logic [`TILE_ADDR_W-1:0] addr,
		logic [2:0] fineY, logic [2:0] fineX);
		logic [15:0] word;
		logic [15:0] known;
		expEntry_s e;
		word = {mirror[{addr, 1'b1}], mirror[{addr, 1'b0}]};
		known = {{8{byteKnown[{addr, 1'b1}]}}, {8{byteKnown[{addr, 1'b0}]}}};
		e.val.patAddr = {word[`TILE_CODE_W-1:0], fineY};
		e.val.attr = word[15:`TILE_CODE_W];
		e.val.fineX = fineX;
		e.mask.patAddr = {known[`TILE_CODE_W-1:0], 3'b111};
		e.mask.attr = known[15:`TILE_CODE_W];
		e.mask.fineX = 3'b111;
		return e;
	endfunction

	// One clock edge, inputs as they were before it
	task automatic modelStep();
		logic hFall;
		logic vFall;
		logic readyExp;
		logic [`POS_W-1:0] x;
		logic [`POS_W-1:0] y;
		logic grant [2];
		logic [12:0] byteAddr;
		int l;
		hFall = hSyncD & ~hSyncN;
		vFall = vSyncD & ~vSyncN;
		// Layer A first, then B, CPU last
		grant[0] = fetchPend[0];
		grant[1] = fetchPend[1] & ~fetchPend[0];
		readyExp = portEn & (cpuReq.regSel | (~fetchPend[0] & ~fetchPend[1]));
		if (readyExp !== readyAtNeg)
			reportFailure("cpuReqReady disagrees with the fixed priority arbitration");
		cpuAccepted = cpuReqValid & readyExp;
		rspExp = cpuAccepted & ~cpuReq.regSel & ~cpuReq.write;
		for (l = 0; l < 2; l++) begin
			x = (flipShadow[l] ? ~hPos : hPos) + scrollXShadow[l];
			y = (flipShadow[l] ? ~vPos : vPos) + scrollYShadow[l];
			outExp[l] = gntStage[l];
			gntStage[l] = grant[l];
			if (grant[l] && l == 0)
				expQA.push_back(makeExpected(reqAddr[l], reqFineY[l], reqFineX[l]));
			else if (grant[l])
				expQB.push_back(makeExpected(reqAddr[l], reqFineY[l], reqFineX[l]));
			if (!fetchPend[l] && x[2:0] == 3'd0) begin
				fetchPend[l] = 1'b1;
				reqAddr[l] = {y[`POS_W-1:3], x[`POS_W-1:3]};
				reqFineY[l] = y[2:0];
				reqFineX[l] = scrollXShadow[l][2:0];
			end else if (grant[l]) begin
				fetchPend[l] = 1'b0;
			end
		end
		// RAM side of the CPU port
		if (cpuAccepted && !cpuReq.regSel) begin
			byteAddr = cpuReq.addr;
			if (cpuReq.write) begin
				mirror[byteAddr] = cpuReq.wdata;
				byteKnown[byteAddr] = 1'b1;
			end else begin
				rspByte = mirror[byteAddr];
			end
		end
		// Shadows see live values from before this edge
		for (l = 0; l < 2; l++) begin
			if (vFall) begin
				scrollXShadow[l] = scrollXLive[l];
				scrollYShadow[l] = scrollYLive[l];
				flipShadow[l] = flipLive[l];
			end
		end
		if (cpuAccepted && cpuReq.regSel && cpuReq.write) begin
			l = cpuReq.addr[2] ? 1 : 0;
			case (cpuReq.addr[1:0])
				2'd0: scrollXLive[l][7:0] = cpuReq.wdata;
				2'd1: begin
					scrollXLive[l][8] = cpuReq.wdata[0];
					flipLive[l] = cpuReq.wdata[7];
				end
				2'd2: scrollYLive[l][7:0] = cpuReq.wdata;
				default: scrollYLive[l][8] = cpuReq.wdata[0];
			endcase
		end
		// Beam counters
		if (hFall) begin
			hPos = '0;
			vPos = (vPending || vFall) ? 9'd0 : vPos + 9'd1;
			vPending = 1'b0;
		end else begin
			hPos = hPos + 9'd1;
			if (vFall)
				vPending = 1'b1;
		end
		hSyncD = hSyncN;
		vSyncD = vSyncN;
		portEn = 1'b1;
	endtask

	task automatic checkFetchOutput(int l, logic gotValid, tilemapPkg::patFetch_s got);
		expEntry_s e;
		if (gotValid !== outExp[l]) begin
			if (gotValid)
				reportFailure("a layer produced a pattern fetch that was never requested");
			else
				reportFailure("a layer dropped a pattern fetch that was granted");
		end
		if (gotValid && l == 0) begin
			e = expQA.pop_front();
			checkPatFetch("patFetchA", got, e.val, e.mask);
		end else if (gotValid) begin
			e = expQB.pop_front();
			checkPatFetch("patFetchB", got, e.val, e.mask);
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	// hsync low 8 cycles, vsync low early in line 0
	task automatic driveSyncs();
		hSyncN = (lineCnt >= 8);
		vSyncN = !(lineIdx == 0 && lineCnt < 16);
		lineCnt++;
		if (lineCnt == lineLen) begin
			lineCnt = 0;
			lineLen = 96 + $urandom % 33;
			lineIdx++;
			if (lineIdx >= frameLines) begin
				lineIdx = 0;
				frameLines = 6 + $urandom % 5;
			end
		end
	endtask

	task automatic newRandomRequest();
		int r;
		r = $urandom % 16;
		cpuReqValid = (r != 15);
		cpuReq.addr = 13'($urandom);
		cpuReq.wdata = 8'($urandom);
		// Mostly RAM traffic, some scroll and flip writes
		if (r < 2) begin
			cpuReq.regSel = 1'b1;
			cpuReq.write = 1'b1;
		end else begin
			cpuReq.regSel = 1'b0;
			cpuReq.write = (r < 9);
		end
	endtask

	// Held until accepted
	task automatic driveCpu(int phase);
		if (!cpuReqValid || cpuAccepted) begin
			if (phase == 1 && fillAddr < ramBytes) begin
				cpuReqValid = 1'b1;
				cpuReq.regSel = 1'b0;
				cpuReq.write = 1'b1;
				cpuReq.addr = fillAddr[12:0];
				cpuReq.wdata = fillByte(fillAddr);
				fillAddr++;
			end else if (phase == 2) begin
				newRandomRequest();
			end else begin
				cpuReqValid = 1'b0;
			end
		end
	endtask

	task automatic runCycle(int phase);
		@(posedge clk6M);
		#2;
		modelStep();
		checkFetchOutput(0, patFetchValidA, patFetchA);
		checkFetchOutput(1, patFetchValidB, patFetchB);
		if (cpuRspValid !== rspExp)
			reportFailure("cpuRspValid was not exactly one cycle after an accepted read");
		if (rspExp)
			checkCpuRdata(cpuRdata, rspByte);
		driveSyncs();
		driveCpu(phase);
	endtask

	initial begin
		void'($urandom(95));
		rstN = 1'b1;
		hSyncN = 1'b1;
		vSyncN = 1'b1;
		cpuReqValid = 1'b0;
		cpuReq = '0;
		for (int i = 0; i < ramBytes; i++) begin
			mirror[i] = 8'h00;
			byteKnown[i] = 1'b0;
		end
		hPos = '0;
		vPos = '0;
		hSyncD = 1'b1;
		vSyncD = 1'b1;
		vPending = 1'b0;
		for (int l = 0; l < 2; l++) begin
			scrollXLive[l] = '0;
			scrollYLive[l] = '0;
			flipLive[l] = 1'b0;
			scrollXShadow[l] = '0;
			scrollYShadow[l] = '0;
			flipShadow[l] = 1'b0;
			fetchPend[l] = 1'b0;
			gntStage[l] = 1'b0;
			outExp[l] = 1'b0;
		end
		portEn = 1'b0;
		rspExp = 1'b0;
		cpuAccepted = 1'b0;
		lineCnt = 0;
		lineLen = 100;
		lineIdx = 1;
		frameLines = 8;
		fillAddr = 0;
		#1 rstN = 1'b0;
		repeat (5) @(posedge clk6M);
		#2 rstN = 1'b1;
		// Whole RAM first, so fetched words are known
		runCycle(1);
		while (fillAddr < ramBytes || cpuReqValid)
			runCycle(1);
		repeat (randomCycles) runCycle(2);
		runCycle(0);
		while (cpuReqValid)
			runCycle(0);
		repeat (drainCycles) runCycle(0);
		// Only a fetch still in the RAM stage may be queued
		if (expQA.size() != (gntStage[0] ? 1 : 0) || expQB.size() != (gntStage[1] ? 1 : 0)) begin
			reportFailure("expected pattern fetches were left over at the end");
		end else begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

//--- tilemapGen.f
+incdir+src
src/tilemapPkg.sv
src/videoTiming.sv
src/tileLayer.sv
src/tileRam.sv
src/tilemapGen.sv
verification/tilemapGen_assertions.sv
verification/tilemapGenTb.sv

//--- runSim.sh
#!/usr/bin/env bash
# Build with Verilator, run, then judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module tilemapGenTb \
	-f tilemapGen.f -o simTilemap > build.log 2>&1 \
	|| { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/simTilemap > sim.log 2>&1
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1
grep -q "SIMULATION PASSED" sim.log || { echo "No pass message in sim.log"; exit 1; }
exit 0
